/* rtl/cfr_consts.svh */
//************************************************************
// Sizes shared by the CFR back end. The pulse table holds two
// interleaved phases, so taps per phase is half the table size
//************************************************************

`ifndef CFR_CONSTS_SVH
`define CFR_CONSTS_SVH

// Width of each I or Q sample, pulse tap and product
`define CFR_DATA_W 16

// Pulse RAM address width for 256 entries and 128 taps per phase
`define CFR_CPW_ADDR_W 8

// Fractional bits of the pulse coefficients
`define CFR_CPW_FRAC_W 14

// Default number of cascaded pulse generator stages
`define CFR_NUM_STAGES 4

`endif

/* rtl/cfr_pkg.sv */
//************************************************************
// Types for the CFR back end. Q sits above I when packed
//************************************************************

`include "cfr_consts.svh"

package cfr_pkg;

  // One complex sample for data, pulse taps and products
  typedef struct packed {
    logic signed [`CFR_DATA_W-1:0] q;
    logic signed [`CFR_DATA_W-1:0] i;
  } iq_t;

  // Peak event from the upstream detector that travels with its strobe
  typedef struct packed {
    iq_t  val;
    logic phase;
  } peak_t;

  // Pulse RAM write port that is broadcast to every stage
  typedef struct packed {
    logic                       en;
    logic [`CFR_CPW_ADDR_W-1:0] addr;
    iq_t                        data;
  } cpw_wr_t;

endpackage

/* rtl/cpw_ram.sv */
//************************************************************
// Pulse RAM with two cycles of read latency; the output is
// zero while the read enable is low. Contents are not reset
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module cpw_ram
  import cfr_pkg::*;
#(
  parameter int ADDR_W = `CFR_CPW_ADDR_W
) (
  input  logic              clk,
  input  cpw_wr_t           wr_i,
  input  logic              rd_en_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output iq_t               rd_data_o
);

  iq_t  mem [2**ADDR_W];
  iq_t  mem_q;
  logic rd_en_q;

  // Write port
  always_ff @(posedge clk) begin
    if (wr_i.en) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

  // First read stage registers the memory word itself
  always_ff @(posedge clk) begin
    rd_en_q <= rd_en_i;
    if (rd_en_i) begin
      mem_q <= mem[rd_addr_i];
    end
  end

  // Output register is forced to zero when idle so that
  // downstream products vanish
  always_ff @(posedge clk) begin
    if (rd_en_q) begin
      rd_data_o <= mem_q;
    end else begin
      rd_data_o <= '0;
    end
  end

endmodule

/* rtl/pipe_delay.sv */
//************************************************************
// Fixed delay line of DEPTH registers. DEPTH must be 1 or more
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module pipe_delay
  import cfr_pkg::*;
#(
  parameter type T     = iq_t,
  parameter int  DEPTH = 2
) (
  input  logic clk,
  input  logic rst,
  input  T     d_i,
  output T     q_o
);

  T stage [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < DEPTH; k++) begin
        stage[k] <= '0;
      end
    end else begin
      stage[0] <= d_i;
      for (int k = 1; k < DEPTH; k++) begin
        stage[k] <= stage[k-1];
      end
    end
  end

  assign q_o = stage[DEPTH-1];

endmodule

/* rtl/iq_cmult.sv */
//************************************************************
// Complex multiply with 3 cycles of latency and one pair per cycle.
// The result is shifted right by the coefficient fraction and saturated
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module iq_cmult
  import cfr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  iq_t  a_i,
  input  iq_t  b_i,
  output iq_t  p_o
);

  localparam int W    = `CFR_DATA_W;
  localparam int PW   = 2 * W;
  localparam int SW   = PW + 1;
  localparam int FRAC = `CFR_CPW_FRAC_W;

  localparam logic signed [SW-1:0] SAT_HI = (1 <<< (W - 1)) - 1;
  localparam logic signed [SW-1:0] SAT_LO = -(1 <<< (W - 1));

  iq_t                  a_q;
  iq_t                  b_q;
  logic signed [PW-1:0] pp_ii;
  logic signed [PW-1:0] pp_qq;
  logic signed [PW-1:0] pp_iq;
  logic signed [PW-1:0] pp_qi;
  logic signed [SW-1:0] re_sum;
  logic signed [SW-1:0] im_sum;

  // Clamp a shifted sum back into the sample range
  function automatic logic signed [W-1:0] sat_w(input logic signed [SW-1:0] x);
    logic signed [W-1:0] res;
    if (x > SAT_HI) begin
      res = SAT_HI[W-1:0];
    end else if (x < SAT_LO) begin
      res = SAT_LO[W-1:0];
    end else begin
      res = x[W-1:0];
    end
    return res;
  endfunction

  //**********************************************************
  // Pipeline
  //**********************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q   <= '0;
      b_q   <= '0;
      pp_ii <= '0;
      pp_qq <= '0;
      pp_iq <= '0;
      pp_qi <= '0;
      p_o   <= '0;
    end else begin
      a_q   <= a_i;
      b_q   <= b_i;
      pp_ii <= a_q.i * b_q.i;
      pp_qq <= a_q.q * b_q.q;
      pp_iq <= a_q.i * b_q.q;
      pp_qi <= a_q.q * b_q.i;
      p_o.i <= sat_w(re_sum >>> FRAC);
      p_o.q <= sat_w(im_sum >>> FRAC);
    end
  end

  // One guard bit keeps the sums exact before the shift
  assign re_sum = pp_ii - pp_qq;
  assign im_sum = pp_iq + pp_qi;

endmodule

/* rtl/iq_sat_sub.sv */
//************************************************************
// Registered complex a - b with each part clamped to 16 bits
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module iq_sat_sub
  import cfr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  iq_t  a_i,
  input  iq_t  b_i,
  output iq_t  d_o
);

  localparam int W = `CFR_DATA_W;

  logic signed [W:0] diff_i;
  logic signed [W:0] diff_q;

  // Overflow shows as the two top bits differing
  function automatic logic signed [W-1:0] clamp(input logic signed [W:0] x);
    logic signed [W-1:0] res;
    if (x[W] != x[W-1]) begin
      res = x[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
    end else begin
      res = x[W-1:0];
    end
    return res;
  endfunction

  assign diff_i = a_i.i - b_i.i;
  assign diff_q = a_i.q - b_i.q;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_o <= '0;
    end else begin
      d_o.i <= clamp(diff_i);
      d_o.q <= clamp(diff_q);
    end
  end

endmodule

/* rtl/cpg_stage.sv */
//************************************************************
// One cancelling-pulse stage with 1 cycle of data latency. A busy
// stage forwards new peaks and there is no back-pressure
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module cpg_stage
  import cfr_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  iq_t     data_i,
  input  peak_t   peak_i,
  input  logic    peak_valid_i,
  input  cpw_wr_t cpw_wr_i,
  output iq_t     data_o,
  output peak_t   peak_o,
  output logic    peak_valid_o
);

  localparam int ADDR_W = `CFR_CPW_ADDR_W;
  localparam int TAP_W  = ADDR_W - 1;

  logic              busy;
  logic              accept;
  logic [TAP_W-1:0]  tap_cnt;
  iq_t               peak_val;
  logic              peak_phase;
  logic [ADDR_W-1:0] rd_addr;
  iq_t               tap_data;
  iq_t               peak_val_d;
  iq_t               product;

  //**********************************************************
  // Peak allocation
  //**********************************************************

  assign accept = peak_valid_i & ~busy;

  // Busy for exactly one pass of the tap counter
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      tap_cnt <= '0;
    end else begin
      if (accept) begin
        busy <= 1'b1;
      end else if (busy && (&tap_cnt)) begin
        busy <= 1'b0;
      end
      if (busy) begin
        tap_cnt <= tap_cnt + 1'b1;
      end
    end
  end

  // Captured peak stays put until the next accept
  always_ff @(posedge clk) begin
    if (rst) begin
      peak_val   <= '0;
      peak_phase <= 1'b0;
    end else if (accept) begin
      peak_val   <= peak_i.val;
      peak_phase <= peak_i.phase;
    end
  end

  // Pass on what we cannot take
  always_ff @(posedge clk) begin
    if (rst) begin
      peak_valid_o <= 1'b0;
      peak_o       <= '0;
    end else begin
      peak_valid_o <= peak_valid_i & busy;
      if (peak_valid_i && busy) begin
        peak_o <= peak_i;
      end else begin
        peak_o <= '0;
      end
    end
  end

  //**********************************************************
  // Pulse datapath
  //**********************************************************

  // Phase 0 reads the odd entries, phase 1 the even ones
  assign rd_addr = {tap_cnt, ~peak_phase};

  cpw_ram #(
    .ADDR_W(ADDR_W)
  ) i_cpw_ram (
    .clk      (clk),
    .wr_i     (cpw_wr_i),
    .rd_en_i  (busy),
    .rd_addr_i(rd_addr),
    .rd_data_o(tap_data)
  );

  // Match the two cycles of RAM read latency
  pipe_delay #(
    .T    (iq_t),
    .DEPTH(2)
  ) i_val_dly (
    .clk(clk),
    .rst(rst),
    .d_i(peak_val),
    .q_o(peak_val_d)
  );

  iq_cmult i_cmult (
    .clk(clk),
    .rst(rst),
    .a_i(peak_val_d),
    .b_i(tap_data),
    .p_o(product)
  );

  iq_sat_sub i_sub (
    .clk(clk),
    .rst(rst),
    .a_i(data_i),
    .b_i(product),
    .d_o(data_o)
  );

endmodule

/* rtl/cfr_cpg_chain.sv */
//************************************************************
// Cascade of pulse stages with a data latency of NUM_STAGES cycles.
// All stages share one pulse table written through cpw_wr_i
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module cfr_cpg_chain
  import cfr_pkg::*;
#(
  parameter int NUM_STAGES = `CFR_NUM_STAGES
) (
  input  logic    clk,
  input  logic    rst,
  input  iq_t     data_i,
  input  peak_t   peak_i,
  input  logic    peak_valid_i,
  input  cpw_wr_t cpw_wr_i,
  output iq_t     data_o,
  output peak_t   peak_drop_o,
  output logic    peak_drop_valid_o
);

  // Index k is the input of stage k, index NUM_STAGES the chain output
  iq_t   data_w       [NUM_STAGES+1];
  peak_t peak_w       [NUM_STAGES+1];
  logic  peak_valid_w [NUM_STAGES+1];

  assign data_w[0]       = data_i;
  assign peak_w[0]       = peak_i;
  assign peak_valid_w[0] = peak_valid_i;

  for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
    cpg_stage i_stage (
      .clk         (clk),
      .rst         (rst),
      .data_i      (data_w[k]),
      .peak_i      (peak_w[k]),
      .peak_valid_i(peak_valid_w[k]),
      .cpw_wr_i    (cpw_wr_i),
      .data_o      (data_w[k+1]),
      .peak_o      (peak_w[k+1]),
      .peak_valid_o(peak_valid_w[k+1])
    );
  end

  // Peaks leaving the last stage found no free stage
  assign data_o            = data_w[NUM_STAGES];
  assign peak_drop_o       = peak_w[NUM_STAGES];
  assign peak_drop_valid_o = peak_valid_w[NUM_STAGES];

endmodule

/* test/tb_cpg_model.svh */
//************************************************************
// Reference model of the stage chain that is included inside the
// testbench module. Arrays hold MAX_CYC cycles after reset
//************************************************************

`ifndef TB_CPG_MODEL_SVH
`define TB_CPG_MODEL_SVH

localparam int MAX_CYC   = 4096;
localparam int NSTG      = `CFR_NUM_STAGES;
localparam int TAPS      = 2 ** (`CFR_CPW_ADDR_W - 1);
// Tap n meets the sample taken 6+n edges after the peak
localparam int PULSE_LAG = 6;

iq_t   pulse_tab  [2 ** `CFR_CPW_ADDR_W];
iq_t   prod_tab   [NSTG][MAX_CYC];
iq_t   exp_data   [MAX_CYC];
peak_t exp_drop   [MAX_CYC];
logic  exp_drop_v [MAX_CYC];
int    busy_cnt   [NSTG];
peak_t cap_peak   [NSTG];

function automatic logic signed [`CFR_DATA_W-1:0] sat_ref(input longint x);
  longint hi;
  longint lo;
  hi = (longint'(1) <<< (`CFR_DATA_W - 1)) - 1;
  lo = -hi - 1;
  if (x > hi) begin
    x = hi;
  end else if (x < lo) begin
    x = lo;
  end
  return x[`CFR_DATA_W-1:0];
endfunction

// Complex product scaled down by the coefficient fraction
function automatic iq_t cmul_ref(input iq_t a, input iq_t c);
  iq_t    p;
  longint re;
  longint im;
  re  = longint'(a.i) * c.i - longint'(a.q) * c.q;
  im  = longint'(a.i) * c.q + longint'(a.q) * c.i;
  p.i = sat_ref(re >>> `CFR_CPW_FRAC_W);
  p.q = sat_ref(im >>> `CFR_CPW_FRAC_W);
  return p;
endfunction

function automatic iq_t sub_ref(input iq_t a, input iq_t b);
  iq_t d;
  d.i = sat_ref(longint'(a.i) - b.i);
  d.q = sat_ref(longint'(a.q) - b.q);
  return d;
endfunction

function automatic void model_init();
  for (int c = 0; c < MAX_CYC; c++) begin
    exp_data[c]   = '0;
    exp_drop[c]   = '0;
    exp_drop_v[c] = 1'b0;
    for (int k = 0; k < NSTG; k++) begin
      prod_tab[k][c] = '0;
    end
  end
  for (int k = 0; k < NSTG; k++) begin
    busy_cnt[k] = 0;
    cap_peak[k] = '0;
  end
endfunction

// One input edge c. Stage k really sees the peak k edges later,
// as does the data, so all stages are handled in the input frame
function automatic void model_step(input int c, input iq_t x, input peak_t pk, input logic pv);
  logic pend;
  iq_t  acc;
  int   addr;
  pend = pv;
  for (int k = 0; k < NSTG; k++) begin
    if (pend && busy_cnt[k] == 0) begin
      cap_peak[k] = pk;
      busy_cnt[k] = TAPS;
      pend        = 1'b0;
      // Phase 0 uses the odd entries, phase 1 the even ones
      for (int n = 0; n < TAPS; n++) begin
        addr = 2 * n + (cap_peak[k].phase ? 0 : 1);
        prod_tab[k][c + PULSE_LAG + n] = cmul_ref(cap_peak[k].val, pulse_tab[addr]);
      end
    end else if (busy_cnt[k] > 0) begin
      busy_cnt[k]--;
    end
  end
  // Results leave the last stage after edge c+NSTG-1
  if (pend) begin
    exp_drop[c + NSTG - 1]   = pk;
    exp_drop_v[c + NSTG - 1] = 1'b1;
  end
  acc = x;
  for (int k = 0; k < NSTG; k++) begin
    acc = sub_ref(acc, prod_tab[k][c]);
  end
  exp_data[c + NSTG - 1] = acc;
endfunction

`endif

/* test/tb_cfr_cpg_chain.sv */
//************************************************************
// Testbench for cfr_cpg_chain with the default 4 stages. Inputs
// change on the falling edge and outputs are also read there
//************************************************************

`timescale 1ns/10ps

`include "cfr_consts.svh"

module tb_cfr_cpg_chain
  import cfr_pkg::*;
();

  localparam int CLK_HALF  = 4;
  localparam int RST_CYC   = 5;
  localparam int LOAD_CYC  = 2 ** `CFR_CPW_ADDR_W + 1;
  localparam int T1_CYC    = 200;
  localparam int T2_CYC    = 300;
  localparam int T3_CYC    = 450;
  localparam int T4_CYC    = 320;
  localparam int T5_CYC    = 320;
  localparam int T6_CYC    = 320;
  localparam int RUN_CYC   = RST_CYC + LOAD_CYC + T1_CYC + T2_CYC + T3_CYC
                           + T4_CYC + T5_CYC + T6_CYC;
  localparam int WATCH_CYC = RUN_CYC + 200;

  logic    clk = 1'b0;
  logic    rst = 1'b1;
  iq_t     data_i;
  peak_t   peak_i;
  logic    peak_valid_i;
  cpw_wr_t cpw_wr_i;
  iq_t     data_o;
  peak_t   peak_drop_o;
  logic    peak_drop_valid_o;

  int      seed;
  int      cyc;
  int      err_count;
  int      chk_count;
  int      test_count;
  int      errs_start;
  int      sched_at [$];
  peak_t   sched_pk [$];

  `include "tb_cpg_model.svh"

  cfr_cpg_chain dut_i (
    .clk              (clk),
    .rst              (rst),
    .data_i           (data_i),
    .peak_i           (peak_i),
    .peak_valid_i     (peak_valid_i),
    .cpw_wr_i         (cpw_wr_i),
    .data_o           (data_o),
    .peak_drop_o      (peak_drop_o),
    .peak_drop_valid_o(peak_drop_valid_o)
  );

  always #CLK_HALF clk = ~clk;

  //**********************************************************
  // Checking
  //**********************************************************

  task automatic check_value(input string name, input logic [39:0] exp_v,
                             input logic [39:0] act_v);
    chk_count++;
    if (act_v !== exp_v) begin
      err_count++;
      $display("mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  // Inputs seen here are the ones sampled on the last rising edge
  always @(negedge clk) begin
    if (!rst) begin
      model_step(cyc, data_i, peak_i, peak_valid_i);
      check_value("data_o", exp_data[cyc], data_o);
      check_value("peak_drop_valid_o", exp_drop_v[cyc], peak_drop_valid_o);
      check_value("peak_drop_o", exp_drop[cyc], peak_drop_o);
      cyc++;
    end
  end

  //**********************************************************
  // Stimulus
  //**********************************************************

  function automatic int fs_value();
    int m;
    m = 32767 - ($random(seed) & 255);
    return ($random(seed) & 1) ? m : -m;
  endfunction

  function automatic iq_t data_sample(input bit near_fs);
    iq_t s;
    if (near_fs) begin
      s.i = fs_value();
      s.q = fs_value();
    end else begin
      s.i = $random(seed) % 16384;
      s.q = $random(seed) % 16384;
    end
    return s;
  endfunction

  // Coefficients within +-8192 are copied into the model table
  task automatic load_table();
    cpw_wr_t w;
    for (int a = 0; a < 2 ** `CFR_CPW_ADDR_W; a++) begin
      w.en        = 1'b1;
      w.addr      = a[`CFR_CPW_ADDR_W-1:0];
      w.data.i    = $random(seed) % 8193;
      w.data.q    = $random(seed) % 8193;
      pulse_tab[a] = w.data;
      @(negedge clk);
      cpw_wr_i <= w;
    end
    @(negedge clk);
    cpw_wr_i <= '0;
  endtask

  // Offsets count from the start of the next window and must rise
  task automatic schedule_peak(input int at, input int vi, input int vq, input bit ph);
    peak_t p;
    p.val.i = vi;
    p.val.q = vq;
    p.phase = ph;
    sched_at.push_back(at);
    sched_pk.push_back(p);
  endtask

  task automatic run_window(input int len, input bit near_fs);
    peak_t pk;
    logic  pv;
    for (int n = 0; n < len; n++) begin
      pk = '0;
      pv = 1'b0;
      if (sched_at.size() > 0 && sched_at[0] == n) begin
        pk = sched_pk.pop_front();
        pv = 1'b1;
        void'(sched_at.pop_front());
      end
      @(negedge clk);
      data_i       <= data_sample(near_fs);
      peak_i       <= pk;
      peak_valid_i <= pv;
    end
  endtask

  task automatic end_test(input string name, input int start_errs);
    test_count++;
    $display("test %0d, %s: %0d errors", test_count, name, err_count - start_errs);
  endtask

  initial begin : main
    seed         = 32'h50e5;
    data_i       = '0;
    peak_i       = '0;
    peak_valid_i = 1'b0;
    cpw_wr_i     = '0;
    cyc          = 0;
    err_count    = 0;
    chk_count    = 0;
    test_count   = 0;
    model_init();
    repeat (RST_CYC) @(negedge clk);
    rst <= 1'b0;
    load_table();

    errs_start = err_count;
    run_window(T1_CYC, 1'b0);
    end_test("pass-through without peaks", errs_start);

    errs_start = err_count;
    schedule_peak(20, 12000, -7000, 1'b0);
    run_window(T2_CYC, 1'b0);
    end_test("single phase 0 peak", errs_start);

    // Stages 1 to 3 are still busy when the first pulse ends, so the peak
    // one edge early is dropped and the next one can only go to stage 0
    errs_start = err_count;
    schedule_peak(20, -9000, 11000, 1'b1);
    schedule_peak(100, 5000, -4000, 1'b0);
    schedule_peak(105, -6000, 2000, 1'b1);
    schedule_peak(110, 3000, 7000, 1'b0);
    schedule_peak(20 + TAPS, 1111, -2222, 1'b1);
    schedule_peak(20 + TAPS + 1, 8000, 8000, 1'b1);
    run_window(T3_CYC, 1'b0);
    end_test("phase 1 peak and stage reuse", errs_start);

    errs_start = err_count;
    schedule_peak(10, 10000, 3000, 1'b0);
    schedule_peak(13, -6000, 9000, 1'b1);
    schedule_peak(17, 4000, -12000, 1'b0);
    schedule_peak(22, -11000, -5000, 1'b1);
    run_window(T4_CYC, 1'b0);
    end_test("four overlapping peaks", errs_start);

    errs_start = err_count;
    schedule_peak(10, 7000, 7000, 1'b0);
    schedule_peak(12, -7000, 5000, 1'b1);
    schedule_peak(14, 9000, -2000, 1'b0);
    schedule_peak(16, -3000, -9000, 1'b1);
    schedule_peak(40, 12345, -4321, 1'b1);
    schedule_peak(60, -2222, 3333, 1'b0);
    run_window(T5_CYC, 1'b0);
    end_test("peaks dropped with all stages busy", errs_start);

    errs_start = err_count;
    schedule_peak(15, 30000, -30000, 1'b0);
    schedule_peak(18, -28000, 29000, 1'b1);
    run_window(T6_CYC, 1'b1);
    end_test("saturation near full scale", errs_start);

    $display("%0d tests, %0d checks, %0d errors", test_count, chk_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCH_CYC * 2 * CLK_HALF);
    $display("Watchdog expired: the run did not finish within %0d cycles", WATCH_CYC);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* list.f */
+incdir+rtl
+incdir+test
rtl/cfr_pkg.sv
rtl/cpw_ram.sv
rtl/pipe_delay.sv
rtl/iq_cmult.sv
rtl/iq_sat_sub.sv
rtl/cpg_stage.sv
rtl/cfr_cpg_chain.sv
test/tb_cfr_cpg_chain.sv
